/* rot_pkg.sv */
package rot_pkg;

    // stream and bus widths
    localparam int sample_w    = 16;
    localparam int wide_w      = 2 * sample_w + 1;
    localparam int shift_w     = 5;
    localparam int count_w     = 16;
    localparam int axil_addr_w = 4;
    localparam int axil_data_w = 32;

    typedef logic signed [sample_w-1:0] sample_t;
    typedef logic signed [wide_w-1:0]   wide_t;
    typedef logic [shift_w-1:0]         shift_t;
    typedef logic [count_w-1:0]         count_t;
    typedef logic [axil_addr_w-1:0]     axil_addr_t;
    typedef logic [axil_data_w-1:0]     axil_data_t;
    typedef logic [1:0]                 axil_resp_t;

    typedef struct packed {
        sample_t re;
        sample_t im;
    } iq_sample_t;

    typedef struct packed {
        wide_t re;
        wide_t im;
    } iq_wide_t;

    typedef struct packed {
        iq_sample_t coef;
        shift_t     shift;
    } rot_cfg_t;

    // manager side of the config bus
    typedef struct packed {
        axil_addr_t awaddr;
        logic       awvalid;
        axil_data_t wdata;
        logic       wvalid;
        logic       bready;
        axil_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } axil_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        axil_resp_t bresp;
        logic       bvalid;
        logic       arready;
        axil_data_t rdata;
        axil_resp_t rresp;
        logic       rvalid;
    } axil_rsp_t;

    typedef enum logic {
        idle,
        resp
    } axil_state_t;

    localparam axil_addr_t addr_coef_re   = 4'h0;
    localparam axil_addr_t addr_coef_im   = 4'h4;
    localparam axil_addr_t addr_shift     = 4'h8;
    localparam axil_addr_t addr_sat_count = 4'hC;

    localparam axil_resp_t resp_okay   = 2'b00;
    localparam axil_resp_t resp_slverr = 2'b10;

    // clamp limits of one output component
    localparam sample_t sample_max = sample_t'({1'b0, {(sample_w-1){1'b1}}});
    localparam sample_t sample_min = sample_t'({1'b1, {(sample_w-1){1'b0}}});

    // coefficient 1.0 in q1.14, shifted back by 14
    localparam int unity_shift = 14;
    localparam rot_cfg_t cfg_reset = '{
        coef:  '{re: sample_t'(1 << unity_shift), im: '0},
        shift: shift_t'(unity_shift)
    };

    localparam int mult_latency  = 3;
    localparam int cmult_latency = 1 + mult_latency + 1;
    localparam int rot_latency   = cmult_latency + 1;

endpackage

/* dsp_mult.sv */
`timescale 1ns/1ns

module dsp_mult #(
    parameter int a_w = 16,
    parameter int b_w = 16
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic signed [a_w-1:0]    a,
    input  logic signed [b_w-1:0]    b,
    input  logic                     din_valid,
    output logic signed [a_w+b_w-1:0] p,
    output logic                     dout_valid
);

    logic signed [a_w-1:0]     a_r;
    logic signed [b_w-1:0]     b_r;
    logic signed [a_w+b_w-1:0] prod_r;
    logic signed [a_w+b_w-1:0] p_r;
    logic [rot_pkg::mult_latency-1:0] valid_sr;

    // input, product and output registers, the usual hard multiplier pipeline
    always_ff @(posedge clk) begin
        a_r    <= a;
        b_r    <= b;
        prod_r <= a_r * b_r;
        p_r    <= prod_r;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_sr <= '0;
        end else begin
            valid_sr <= {valid_sr[rot_pkg::mult_latency-2:0], din_valid};
        end
    end

    assign p          = p_r;
    assign dout_valid = valid_sr[rot_pkg::mult_latency-1];

    // only checked once the whole valid chain has run free of reset
    property valid_delay;
        @(posedge clk) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3))
            |-> dout_valid == $past(din_valid, rot_pkg::mult_latency);
    endproperty

    a_valid_delay: assert property (valid_delay)
        else $error("dsp_mult: dout_valid does not follow din_valid by three cycles");

endmodule

/* complex_mult.sv */
`timescale 1ns/1ns

module complex_mult (
    input  logic                clk,
    input  logic                rst,
    input  rot_pkg::iq_sample_t x,
    input  rot_pkg::iq_sample_t c,
    input  logic                in_valid,
    output rot_pkg::iq_wide_t   y,
    output logic                out_valid
);

    // two copies of each input, one per multiplier pair
    rot_pkg::iq_sample_t x_a;
    rot_pkg::iq_sample_t x_b;
    rot_pkg::iq_sample_t c_a;
    rot_pkg::iq_sample_t c_b;
    logic                valid_a;
    logic                valid_b;

    logic signed [2*rot_pkg::sample_w-1:0] prod_rr;
    logic signed [2*rot_pkg::sample_w-1:0] prod_ri;
    logic signed [2*rot_pkg::sample_w-1:0] prod_ii;
    logic signed [2*rot_pkg::sample_w-1:0] prod_ir;
    logic                                  mult_valid;

    rot_pkg::iq_wide_t y_r;
    logic              out_valid_r;

    always_ff @(posedge clk) begin
        x_a <= x;
        x_b <= x;
        c_a <= c;
        c_b <= c;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_a <= 1'b0;
            valid_b <= 1'b0;
        end else begin
            valid_a <= in_valid;
            valid_b <= in_valid;
        end
    end

    dsp_mult #(.a_w(rot_pkg::sample_w), .b_w(rot_pkg::sample_w)) mult_re_re (
        .clk        (clk),
        .rst        (rst),
        .a          (x_a.re),
        .b          (c_a.re),
        .din_valid  (valid_a),
        .p          (prod_rr),
        .dout_valid (mult_valid)
    );

    dsp_mult #(.a_w(rot_pkg::sample_w), .b_w(rot_pkg::sample_w)) mult_re_im (
        .clk        (clk),
        .rst        (rst),
        .a          (x_b.re),
        .b          (c_b.im),
        .din_valid  (valid_a),
        .p          (prod_ri),
        .dout_valid ()
    );

    dsp_mult #(.a_w(rot_pkg::sample_w), .b_w(rot_pkg::sample_w)) mult_im_im (
        .clk        (clk),
        .rst        (rst),
        .a          (x_a.im),
        .b          (c_a.im),
        .din_valid  (valid_b),
        .p          (prod_ii),
        .dout_valid ()
    );

    dsp_mult #(.a_w(rot_pkg::sample_w), .b_w(rot_pkg::sample_w)) mult_im_re (
        .clk        (clk),
        .rst        (rst),
        .a          (x_b.im),
        .b          (c_b.re),
        .din_valid  (valid_b),
        .p          (prod_ir),
        .dout_valid ()
    );

    // re = xr*cr - xi*ci, im = xr*ci + xi*cr, one growth bit
    always_ff @(posedge clk) begin
        if (mult_valid) begin
            y_r.re <= rot_pkg::wide_t'(prod_rr) - rot_pkg::wide_t'(prod_ii);
            y_r.im <= rot_pkg::wide_t'(prod_ri) + rot_pkg::wide_t'(prod_ir);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_r <= 1'b0;
        end else begin
            out_valid_r <= mult_valid;
        end
    end

    assign y         = y_r;
    assign out_valid = out_valid_r;

    property cmult_delay;
        @(posedge clk) disable iff (rst)
        (!$past(rst, 1) && !$past(rst, 2) && !$past(rst, 3) &&
         !$past(rst, 4) && !$past(rst, 5))
            |-> out_valid == $past(in_valid, rot_pkg::cmult_latency);
    endproperty

    a_cmult_delay: assert property (cmult_delay)
        else $error("complex_mult: out_valid does not follow in_valid by five cycles");

endmodule

/* iq_round_sat.sv */
`timescale 1ns/1ns

module iq_round_sat (
    input  logic                clk,
    input  logic                rst,
    input  rot_pkg::iq_wide_t   y,
    input  logic                in_valid,
    input  rot_pkg::shift_t     shift,
    output rot_pkg::iq_sample_t z,
    output logic                out_valid,
    output logic                sat_pulse
);

    rot_pkg::iq_sample_t z_next;
    rot_pkg::iq_sample_t z_r;
    logic                clamp_re;
    logic                clamp_im;
    logic                out_valid_r;
    logic                sat_r;

    // round half up, arithmetic shift, clamp to the sample range
    function automatic rot_pkg::sample_t round_sat(
        input  rot_pkg::wide_t  v,
        input  rot_pkg::shift_t sh,
        output logic            clamped
    );
        logic signed [rot_pkg::wide_w:0] acc;
        logic signed [rot_pkg::wide_w:0] bias;
        bias = (sh == '0) ? '0 : (rot_pkg::wide_w + 1)'(1) << (sh - 1'b1);
        // one extra bit so the bias never wraps
        acc  = v;
        acc  = acc + bias;
        acc  = acc >>> sh;
        clamped = 1'b1;
        if (acc > rot_pkg::sample_max) begin
            round_sat = rot_pkg::sample_max;
        end else if (acc < rot_pkg::sample_min) begin
            round_sat = rot_pkg::sample_min;
        end else begin
            round_sat = acc[rot_pkg::sample_w-1:0];
            clamped   = 1'b0;
        end
    endfunction

    always_comb begin
        z_next.re = round_sat(y.re, shift, clamp_re);
        z_next.im = round_sat(y.im, shift, clamp_im);
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            z_r <= z_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_r <= 1'b0;
            sat_r       <= 1'b0;
        end else begin
            out_valid_r <= in_valid;
            sat_r       <= in_valid && (clamp_re || clamp_im);
        end
    end

    assign z         = z_r;
    assign out_valid = out_valid_r;
    assign sat_pulse = sat_r;

    a_valid_origin: assert property (@(posedge clk) disable iff (rst)
        $rose(out_valid) |-> $past(in_valid))
        else $error("iq_round_sat: out_valid rose without an input sample");

endmodule

/* axil_regs.sv */
`timescale 1ns/1ns

module axil_regs (
    input  logic               clk,
    input  logic               rst,
    input  rot_pkg::axil_req_t req,
    output rot_pkg::axil_rsp_t rsp,
    input  logic               sat_pulse,
    output rot_pkg::rot_cfg_t  cfg
);

    rot_pkg::axil_state_t wr_state;
    logic                 wr_ready;
    logic                 wr_hs;
    rot_pkg::axil_resp_t  bresp_r;

    logic                 rd_ready;
    logic                 rd_hs;
    logic                 rvalid_r;
    rot_pkg::axil_data_t  rdata_r;
    rot_pkg::axil_resp_t  rresp_r;
    rot_pkg::axil_data_t  rd_word;

    rot_pkg::rot_cfg_t    cfg_r;
    rot_pkg::count_t      sat_count;
    logic                 sat_clr;

    function automatic logic is_mapped(input rot_pkg::axil_addr_t a);
        is_mapped = (a == rot_pkg::addr_coef_re) || (a == rot_pkg::addr_coef_im) ||
                    (a == rot_pkg::addr_shift)   || (a == rot_pkg::addr_sat_count);
    endfunction

    // write channel, ready pulses once both address and data are up
    assign wr_hs = wr_ready && req.awvalid && req.wvalid;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state <= rot_pkg::idle;
            wr_ready <= 1'b0;
        end else begin
            wr_ready <= 1'b0;
            case (wr_state)
                rot_pkg::idle: begin
                    if (wr_hs) begin
                        wr_state <= rot_pkg::resp;
                    end else if (!wr_ready && req.awvalid && req.wvalid) begin
                        wr_ready <= 1'b1;
                    end
                end
                rot_pkg::resp: begin
                    if (req.bready) begin
                        wr_state <= rot_pkg::idle;
                    end
                end
                default: wr_state <= rot_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_hs) begin
            bresp_r <= is_mapped(req.awaddr) ? rot_pkg::resp_okay : rot_pkg::resp_slverr;
        end
    end

    // whole-register writes, no strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_r <= rot_pkg::cfg_reset;
        end else if (wr_hs) begin
            case (req.awaddr)
                rot_pkg::addr_coef_re: cfg_r.coef.re <= req.wdata[rot_pkg::sample_w-1:0];
                rot_pkg::addr_coef_im: cfg_r.coef.im <= req.wdata[rot_pkg::sample_w-1:0];
                rot_pkg::addr_shift:   cfg_r.shift   <= req.wdata[rot_pkg::shift_w-1:0];
                default: ;
            endcase
        end
    end

    // clear beats a same-cycle increment, count sticks at all ones
    assign sat_clr = wr_hs && (req.awaddr == rot_pkg::addr_sat_count);

    always_ff @(posedge clk) begin
        if (rst) begin
            sat_count <= '0;
        end else if (sat_clr) begin
            sat_count <= '0;
        end else if (sat_pulse && sat_count != '1) begin
            sat_count <= sat_count + 1'b1;
        end
    end

    // read channel
    assign rd_hs = rd_ready && req.arvalid;

    always_comb begin
        rd_word = '0;
        case (req.araddr)
            rot_pkg::addr_coef_re:   rd_word[rot_pkg::sample_w-1:0] = cfg_r.coef.re;
            rot_pkg::addr_coef_im:   rd_word[rot_pkg::sample_w-1:0] = cfg_r.coef.im;
            rot_pkg::addr_shift:     rd_word[rot_pkg::shift_w-1:0]  = cfg_r.shift;
            rot_pkg::addr_sat_count: rd_word[rot_pkg::count_w-1:0]  = sat_count;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ready <= 1'b0;
            rvalid_r <= 1'b0;
        end else begin
            rd_ready <= 1'b0;
            if (rd_hs) begin
                rvalid_r <= 1'b1;
            end else if (rvalid_r) begin
                rvalid_r <= !req.rready;
            end else if (!rd_ready && req.arvalid) begin
                rd_ready <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rdata_r <= rd_word;
            rresp_r <= is_mapped(req.araddr) ? rot_pkg::resp_okay : rot_pkg::resp_slverr;
        end
    end

    always_comb begin
        rsp.awready = wr_ready;
        rsp.wready  = wr_ready;
        rsp.bresp   = bresp_r;
        rsp.bvalid  = (wr_state == rot_pkg::resp);
        rsp.arready = rd_ready;
        rsp.rdata   = rdata_r;
        rsp.rresp   = rresp_r;
        rsp.rvalid  = rvalid_r;
    end

    assign cfg = cfg_r;

    a_bvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp))
        else $error("axil_regs: write response dropped before bready");

    a_rvalid_hold: assert property (@(posedge clk) disable iff (rst)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata))
        else $error("axil_regs: read response changed before rready");

endmodule

/* iq_rotator_top.sv */
`timescale 1ns/1ns

module iq_rotator_top (
    input  logic                clk,
    input  logic                rst,
    input  rot_pkg::axil_req_t  axil_req,
    output rot_pkg::axil_rsp_t  axil_rsp,
    input  rot_pkg::iq_sample_t in_sample,
    input  logic                in_valid,
    output rot_pkg::iq_sample_t out_sample,
    output logic                out_valid
);

    rot_pkg::rot_cfg_t cfg;
    rot_pkg::iq_wide_t prod;
    logic              prod_valid;
    logic              sat_pulse;

    // config registers and saturation counter
    axil_regs u_regs (
        .clk       (clk),
        .rst       (rst),
        .req       (axil_req),
        .rsp       (axil_rsp),
        .sat_pulse (sat_pulse),
        .cfg       (cfg)
    );

    // full-width complex product, five cycles
    complex_mult u_cmult (
        .clk       (clk),
        .rst       (rst),
        .x         (in_sample),
        .c         (cfg.coef),
        .in_valid  (in_valid),
        .y         (prod),
        .out_valid (prod_valid)
    );

    // scale back to sample width, one more cycle
    iq_round_sat u_round (
        .clk       (clk),
        .rst       (rst),
        .y         (prod),
        .in_valid  (prod_valid),
        .shift     (cfg.shift),
        .z         (out_sample),
        .out_valid (out_valid),
        .sat_pulse (sat_pulse)
    );

endmodule

/* tb_iq_rotator.sv */
`timescale 1ns/1ns

module tb_iq_rotator;

    localparam int latency       = 6;
    localparam int n_basic       = 100;
    localparam int n_settings    = 6;
    localparam int n_per_setting = 500;
    localparam int n_gap         = 50;
    localparam int n_sat         = 200;
    localparam int n_unmapped    = 6;
    localparam int n_bp          = 20;
    localparam int total_samples = n_basic + n_settings * (n_per_setting + n_gap) + n_sat;
    // reads and writes of every test, in order
    localparam int n_axil = 4 + n_settings * 4 + 4 + 2 + (2 * n_unmapped + 4) + n_bp;
    localparam int cycle_limit = 4 * (total_samples + 200 * n_axil);

    logic                clk = 1'b0;
    logic                rst;
    rot_pkg::axil_req_t  axil_req;
    rot_pkg::axil_rsp_t  axil_rsp;
    rot_pkg::iq_sample_t in_sample;
    logic                in_valid;
    rot_pkg::iq_sample_t out_sample;
    logic                out_valid;

    int cycle = 0;
    int n_pass = 0;
    int n_fail = 0;
    int checks_before = 0;
    int fails_before = 0;

    // reference model state
    rot_pkg::iq_sample_t m_coef;
    rot_pkg::shift_t     m_shift;
    rot_pkg::count_t     m_count;
    rot_pkg::iq_sample_t exp_q[$];
    int                  cyc_q[$];

    iq_rotator_top UUT (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .in_sample  (in_sample),
        .in_valid   (in_valid),
        .out_sample (out_sample),
        .out_valid  (out_valid)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    initial begin
        wait (cycle >= cycle_limit);
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Regression failed");
        $finish;
    end

    task automatic check_sample(input rot_pkg::iq_sample_t got, input rot_pkg::iq_sample_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: sample re=%0d im=%0d, expected re=%0d im=%0d",
                     $time, got.re, got.im, exp.re, exp.im);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_count(input rot_pkg::count_t got, input rot_pkg::count_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: saturation count %0d, expected %0d", $time, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_resp(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t: bus response %b, expected %b", $time, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_data(input rot_pkg::axil_data_t got, input rot_pkg::axil_data_t exp);
        if (got !== exp) begin
            $display("FAIL %0t: read data 0x%08h, expected 0x%08h", $time, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic check_latency(input int got, input int exp);
        if (got != exp) begin
            $display("FAIL %0t: output came %0d cycles after input, expected %0d",
                     $time, got, exp);
            n_fail++;
        end else begin
            n_pass++;
        end
    endtask

    task automatic finish_test(input string name);
        $display("test %-14s checks %0d, failures %0d", name,
                 n_pass + n_fail - checks_before, n_fail - fails_before);
        checks_before = n_pass + n_fail;
        fails_before  = n_fail;
    endtask

    // round half up, arithmetic shift, clamp
    function automatic rot_pkg::sample_t scale_component(input longint v, input int sh,
                                                         output bit clamped);
        longint r;
        r = v;
        if (sh > 0) begin
            r = r + (longint'(1) << (sh - 1));
        end
        r = r >>> sh;
        clamped = 1'b1;
        if (r > 32767) begin
            return 16'sh7fff;
        end else if (r < -32768) begin
            return 16'sh8000;
        end
        clamped = 1'b0;
        return rot_pkg::sample_t'(r);
    endfunction

    function automatic void expect_push(input rot_pkg::iq_sample_t s);
        longint              pr;
        longint              pi;
        bit                  cl_re;
        bit                  cl_im;
        rot_pkg::iq_sample_t e;
        pr = longint'(s.re) * longint'(m_coef.re) - longint'(s.im) * longint'(m_coef.im);
        pi = longint'(s.re) * longint'(m_coef.im) + longint'(s.im) * longint'(m_coef.re);
        e.re = scale_component(pr, int'(m_shift), cl_re);
        e.im = scale_component(pi, int'(m_shift), cl_im);
        exp_q.push_back(e);
        cyc_q.push_back(cycle);
        if ((cl_re || cl_im) && m_count != 16'hffff) begin
            m_count = m_count + 1'b1;
        end
    endfunction

    function automatic rot_pkg::axil_data_t reg_model(input rot_pkg::axil_addr_t a);
        case (a)
            rot_pkg::addr_coef_re:   return {16'h0, m_coef.re};
            rot_pkg::addr_coef_im:   return {16'h0, m_coef.im};
            rot_pkg::addr_shift:     return {27'h0, m_shift};
            rot_pkg::addr_sat_count: return {16'h0, m_count};
            default:                 return '0;
        endcase
    endfunction

    // each output pops the oldest expected sample
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("output sample at %0t with no input pending", $time);
                n_fail++;
            end else begin
                check_sample(out_sample, exp_q.pop_front());
                check_latency(cycle - cyc_q.pop_front(), latency);
            end
        end
    end

    task automatic axil_write(input rot_pkg::axil_addr_t a, input rot_pkg::axil_data_t d,
                              input int max_wait, output rot_pkg::axil_resp_t r);
        int hold;
        axil_req.awaddr  = a;
        axil_req.wdata   = d;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid  = 1'b1;
        @(negedge clk);
        while (!axil_rsp.awready) @(negedge clk);
        // address and data are taken in the same cycle
        if (axil_rsp.wready !== 1'b1) begin
            $display("FAIL %0t: wready low while awready is high", $time);
            n_fail++;
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        while (!axil_rsp.bvalid) @(negedge clk);
        r    = axil_rsp.bresp;
        hold = $urandom_range(0, max_wait);
        repeat (hold) begin
            @(negedge clk);
            if (!axil_rsp.bvalid) begin
                $display("write response withdrawn before bready at %0t", $time);
                n_fail++;
            end
            check_resp(axil_rsp.bresp, r);
        end
        axil_req.bready = 1'b1;
        @(negedge clk);
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input rot_pkg::axil_addr_t a, input int max_wait,
                             output rot_pkg::axil_data_t d, output rot_pkg::axil_resp_t r);
        int hold;
        axil_req.araddr  = a;
        axil_req.arvalid = 1'b1;
        @(negedge clk);
        while (!axil_rsp.arready) @(negedge clk);
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        while (!axil_rsp.rvalid) @(negedge clk);
        d    = axil_rsp.rdata;
        r    = axil_rsp.rresp;
        hold = $urandom_range(0, max_wait);
        repeat (hold) begin
            @(negedge clk);
            if (!axil_rsp.rvalid) begin
                $display("read response withdrawn before rready at %0t", $time);
                n_fail++;
            end
            check_data(axil_rsp.rdata, d);
            check_resp(axil_rsp.rresp, r);
        end
        axil_req.rready = 1'b1;
        @(negedge clk);
        axil_req.rready = 1'b0;
    endtask

    task automatic cfg_write(input rot_pkg::axil_addr_t a, input rot_pkg::axil_data_t d,
                             input int max_wait);
        rot_pkg::axil_resp_t r;
        axil_write(a, d, max_wait, r);
        check_resp(r, rot_pkg::resp_okay);
        case (a)
            rot_pkg::addr_coef_re:   m_coef.re = d[15:0];
            rot_pkg::addr_coef_im:   m_coef.im = d[15:0];
            rot_pkg::addr_shift:     m_shift   = d[4:0];
            rot_pkg::addr_sat_count: m_count   = '0;
            default: ;
        endcase
    endtask

    task automatic read_expect(input rot_pkg::axil_addr_t a, input rot_pkg::axil_data_t exp,
                               input rot_pkg::axil_resp_t exp_resp, input int max_wait);
        rot_pkg::axil_data_t d;
        rot_pkg::axil_resp_t r;
        axil_read(a, max_wait, d, r);
        check_resp(r, exp_resp);
        if (a == rot_pkg::addr_sat_count && exp_resp == rot_pkg::resp_okay) begin
            check_count(d[15:0], exp[15:0]);
        end else begin
            check_data(d, exp);
        end
    endtask

    task automatic run_stream(input int n, input bit gaps, input bit full_scale);
        rot_pkg::iq_sample_t s;
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                in_valid = 1'b0;
                repeat ($urandom_range(0, 3)) @(negedge clk);
            end
            if (full_scale) begin
                s.re = $urandom_range(0, 1) ? 16'sh7fff : 16'sh8000;
                s.im = $urandom_range(0, 1) ? 16'sh7fff : 16'sh8000;
            end else begin
                s.re = rot_pkg::sample_t'($urandom);
                s.im = rot_pkg::sample_t'($urandom);
            end
            in_sample = s;
            in_valid  = 1'b1;
            expect_push(s);
            @(negedge clk);
        end
        in_valid = 1'b0;
        // let the pipeline empty before the config may change
        while (exp_q.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    initial begin
        rot_pkg::axil_addr_t a;
        rot_pkg::axil_data_t d;
        rot_pkg::axil_resp_t r;
        void'($urandom(32'h5713_e55e));
        rst       = 1'b1;
        axil_req  = '0;
        in_sample = '0;
        in_valid  = 1'b0;
        m_coef    = '{re: 16'sh4000, im: 16'sh0000};
        m_shift   = 5'd14;
        m_count   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        read_expect(rot_pkg::addr_coef_re, 32'h4000, rot_pkg::resp_okay, 3);
        read_expect(rot_pkg::addr_coef_im, 32'h0, rot_pkg::resp_okay, 3);
        read_expect(rot_pkg::addr_shift, 32'd14, rot_pkg::resp_okay, 3);
        read_expect(rot_pkg::addr_sat_count, 32'h0, rot_pkg::resp_okay, 3);
        run_stream(n_basic, 1'b1, 1'b0);
        finish_test("reset_default");

        for (int k = 0; k < n_settings; k++) begin
            cfg_write(rot_pkg::addr_coef_re, $urandom, 3);
            cfg_write(rot_pkg::addr_coef_im, $urandom, 3);
            cfg_write(rot_pkg::addr_shift, $urandom_range(12, 17), 3);
            run_stream(n_per_setting, 1'b0, 1'b0);
            run_stream(n_gap, 1'b1, 1'b0);
            read_expect(rot_pkg::addr_sat_count, reg_model(rot_pkg::addr_sat_count),
                        rot_pkg::resp_okay, 3);
        end
        finish_test("random_coef");

        cfg_write(rot_pkg::addr_coef_re, 32'h7fff, 3);
        cfg_write(rot_pkg::addr_coef_im, 32'h7000, 3);
        cfg_write(rot_pkg::addr_shift, 32'd0, 3);
        run_stream(n_sat, 1'b0, 1'b1);
        read_expect(rot_pkg::addr_sat_count, reg_model(rot_pkg::addr_sat_count),
                    rot_pkg::resp_okay, 3);
        finish_test("saturation");

        cfg_write(rot_pkg::addr_sat_count, $urandom, 3);
        read_expect(rot_pkg::addr_sat_count, 32'h0, rot_pkg::resp_okay, 3);
        finish_test("count_clear");

        // any address with nonzero low bits is outside the map
        for (int i = 0; i < n_unmapped; i++) begin
            a = (i == 0) ? 4'h1 : rot_pkg::axil_addr_t'($urandom_range(0, 3) * 4 +
                                                       $urandom_range(1, 3));
            axil_write(a, $urandom, 3, r);
            check_resp(r, rot_pkg::resp_slverr);
            read_expect(a, 32'h0, rot_pkg::resp_slverr, 3);
        end
        read_expect(rot_pkg::addr_coef_re, reg_model(rot_pkg::addr_coef_re), rot_pkg::resp_okay, 3);
        read_expect(rot_pkg::addr_coef_im, reg_model(rot_pkg::addr_coef_im), rot_pkg::resp_okay, 3);
        read_expect(rot_pkg::addr_shift, reg_model(rot_pkg::addr_shift), rot_pkg::resp_okay, 3);
        read_expect(rot_pkg::addr_sat_count, reg_model(rot_pkg::addr_sat_count),
                    rot_pkg::resp_okay, 3);
        finish_test("unmapped");

        // long random stalls on bready and rready
        for (int i = 0; i < n_bp / 2; i++) begin
            a = rot_pkg::axil_addr_t'(4 * $urandom_range(0, 2));
            d = $urandom;
            cfg_write(a, d, 20);
            read_expect(a, reg_model(a), rot_pkg::resp_okay, 20);
        end
        finish_test("backpressure");

        if (exp_q.size() != 0) begin
            $display("%0d expected output samples never appeared", exp_q.size());
            n_fail++;
        end
        $display("checks passed %0d, failed %0d", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* files.f */
rot_pkg.sv
dsp_mult.sv
complex_mult.sv
iq_round_sat.sv
axil_regs.sv
iq_rotator_top.sv
tb_iq_rotator.sv

/* Makefile */
VERILATOR := verilator
TOP       := tb_iq_rotator
FILELIST  := files.f
VFLAGS    := --binary --timing --assert
LOG       := sim.log
BIN       := obj_dir/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^Regression passed$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf obj_dir $(LOG)
